/* Bender.yml */
package:
  name: pam_tx

sources:
  - files:
      - logic/pam_pkg.sv
      - logic/srrc_pkg.sv
      - logic/stream_fifo.sv
      - logic/sample_timer.sv
      - logic/tx_ctrl_fsm.sv
      - logic/srrc_tx_filter.sv
      - logic/pam_tx_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_pam_tx.sv

/* all.f */
+incdir+sim
logic/pam_pkg.sv
logic/srrc_pkg.sv
logic/stream_fifo.sv
logic/sample_timer.sv
logic/tx_ctrl_fsm.sv
logic/srrc_tx_filter.sv
logic/pam_tx_top.sv
sim/tb_pam_tx.sv

/* logic/pam_pkg.sv */
package pam_pkg;

    // Symbol code held in the filter history
    typedef enum logic [2:0] {
        SYM_ZERO = 3'd0,
        SYM_N2   = 3'd1,
        SYM_N1   = 3'd2,
        SYM_P1   = 3'd3,
        SYM_P2   = 3'd4
    } sym_code_t;

    // Input symbol stream payload
    typedef struct packed {
        logic [1:0] dibit;
        logic       last;
    } dibit_in_t;

    localparam int IN_FIFO_DEPTH = 4;

    // Gray order so neighbouring levels differ in one bit
    function automatic sym_code_t gray_map(input logic [1:0] dibit);
        sym_code_t code;
        case (dibit)
            2'b00:   code = SYM_N2;
            2'b01:   code = SYM_N1;
            2'b11:   code = SYM_P1;
            default: code = SYM_P2;
        endcase
        return code;
    endfunction

    // Amplitude of each code with none for the flush symbol
    function automatic int sym_level(input sym_code_t code);
        int level;
        case (code)
            SYM_N2:  level = -3;
            SYM_N1:  level = -1;
            SYM_P1:  level = 1;
            SYM_P2:  level = 3;
            default: level = 0;
        endcase
        return level;
    endfunction

endpackage

/* logic/pam_tx_top.sv */
module pam_tx_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  pam_pkg::dibit_in_t    in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output srrc_pkg::sample_out_t out_data
);
    import pam_pkg::*;
    import srrc_pkg::*;

    logic                 sym_valid;
    logic                 sym_ready;
    dibit_in_t            sym_data;
    logic [2:0]           out_free;
    logic [PHASE_W-1:0]   phase;
    logic                 sym_strobe;
    logic                 timer_run;
    logic                 step;
    logic                 shift;
    sym_code_t            new_sym;
    logic                 last_mark;
    logic                 res_valid;
    logic                 res_ready;
    sample_out_t          res_data;

    stream_fifo #(
        .payload_t (dibit_in_t),
        .DEPTH     (IN_FIFO_DEPTH)
    ) u_in_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (in_valid),
        .wr_ready (in_ready),
        .wr_data  (in_data),
        .rd_valid (sym_valid),
        .rd_ready (sym_ready),
        .rd_data  (sym_data),
        .free     ()
    );

    sample_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .run        (timer_run),
        .phase      (phase),
        .sym_strobe (sym_strobe)
    );

    tx_ctrl_fsm u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .sym_valid  (sym_valid),
        .sym_ready  (sym_ready),
        .sym_data   (sym_data),
        .out_free   (out_free),
        .phase      (phase),
        .sym_strobe (sym_strobe),
        .timer_run  (timer_run),
        .step       (step),
        .shift      (shift),
        .new_sym    (new_sym),
        .last_mark  (last_mark)
    );

    srrc_tx_filter u_filter (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .shift     (shift),
        .phase     (phase),
        .new_sym   (new_sym),
        .last_mark (last_mark),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    // Room is reserved through out_free so a filter result never waits
    stream_fifo #(
        .payload_t (sample_out_t),
        .DEPTH     (OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (res_valid),
        .wr_ready (res_ready),
        .wr_data  (res_data),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_data  (out_data),
        .free     (out_free)
    );

    // Every filter result finds a slot in the output FIFO
    a_out_room: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> res_ready)
        else $error("pam_tx_top: filter result dropped at a full output FIFO");

endmodule

/* logic/sample_timer.sv */
module sample_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    output logic [srrc_pkg::PHASE_W-1:0] phase,
    output logic                         sym_strobe
);
    import srrc_pkg::*;

    // Modulo OSR phase that freezes while the pipeline stalls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= '0;
        end else if (run) begin
            if (phase == PHASE_W'(OSR - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Symbol boundary on the first phase of an advancing cycle
    assign sym_strobe = run && (phase == '0);

endmodule

/* logic/srrc_pkg.sv */
package srrc_pkg;
    import pam_pkg::*;

    // Filter geometry
    localparam int OSR       = 4;
    localparam int SPAN_SYMS = 8;
    localparam int NUM_COEFS = SPAN_SYMS * OSR;
    localparam int PHASE_W   = $clog2(OSR);

    // Datapath widths
    localparam int COEF_W   = 16;
    localparam int PROD_W   = 18;
    localparam int SAMPLE_W = PROD_W + 3;

    localparam int OUT_FIFO_DEPTH = 4;

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef coef_t coef_tbl_t [NUM_COEFS];
    typedef prod_t prod_tbl_t [NUM_COEFS];

    // Unit SRRC with rolloff 0.35 and a peak of 2^14 at index 16
    // Index k*OSR+p is tap p of the symbol k slots back
    localparam coef_tbl_t SRRC_COEF = '{
        31, 199, 143, -143, -381, -221, 383, 977,
        854, -329, -2022, -2820, -1267, 3096, 9089, 14325,
        16384, 14325, 9089, 3096, -1267, -2820, -2022, -329,
        854, 977, 383, -221, -381, -143, 143, 199
    };

    // Builds one product table for a given symbol level
    function automatic prod_tbl_t scale_coefs(input int level);
        prod_tbl_t tbl;
        for (int i = 0; i < NUM_COEFS; i++) begin
            tbl[i] = prod_t'(level * int'(SRRC_COEF[i]));
        end
        return tbl;
    endfunction

    // Precomputed products with one table per nonzero level
    localparam prod_tbl_t PROD_P2 = scale_coefs(sym_level(SYM_P2));
    localparam prod_tbl_t PROD_P1 = scale_coefs(sym_level(SYM_P1));
    localparam prod_tbl_t PROD_N1 = scale_coefs(sym_level(SYM_N1));
    localparam prod_tbl_t PROD_N2 = scale_coefs(sym_level(SYM_N2));

    // Output sample stream payload
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] value;
        logic                       last;
    } sample_out_t;

endpackage

/* logic/srrc_tx_filter.sv */
module srrc_tx_filter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         step,
    input  logic                         shift,
    input  logic [srrc_pkg::PHASE_W-1:0] phase,
    input  pam_pkg::sym_code_t           new_sym,
    input  logic                         last_mark,
    output logic                         res_valid,
    output srrc_pkg::sample_out_t        res_data
);
    import pam_pkg::*;
    import srrc_pkg::*;

    sym_code_t                  hist [SPAN_SYMS];
    sym_code_t                  eff  [SPAN_SYMS];
    prod_t                      prod [SPAN_SYMS];
    logic signed [SAMPLE_W-1:0] sum;

    // Picks the product for one slot from the table of its level
    function automatic prod_t lookup(input sym_code_t code, input int idx);
        prod_t p;
        case (code)
            SYM_P2:  p = PROD_P2[idx];
            SYM_P1:  p = PROD_P1[idx];
            SYM_N1:  p = PROD_N1[idx];
            SYM_N2:  p = PROD_N2[idx];
            default: p = '0;
        endcase
        return p;
    endfunction

    // History as seen by this sample
    // On a boundary the new symbol is already in slot 0
    always_comb begin
        eff[0] = shift ? new_sym : hist[0];
        for (int k = 1; k < SPAN_SYMS; k++) begin
            eff[k] = shift ? hist[k-1] : hist[k];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < SPAN_SYMS; k++) begin
                hist[k] <= SYM_ZERO;
            end
        end else if (step && shift) begin
            for (int k = 0; k < SPAN_SYMS; k++) begin
                hist[k] <= eff[k];
            end
        end
    end

    // Slot k uses tap k*OSR plus the current phase
    always_comb begin
        sum = '0;
        for (int k = 0; k < SPAN_SYMS; k++) begin
            prod[k] = lookup(eff[k], k * OSR + int'(phase));
            sum     = sum + prod[k];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= step;
        end
    end

    // Sample held until the next step
    always_ff @(posedge clk) begin
        if (step) begin
            res_data.value <= sum;
            res_data.last  <= last_mark;
        end
    end

    // Controller only moves the history together with a sample
    a_shift_with_step: assert property (@(posedge clk) disable iff (reset)
        shift |-> step)
        else $error("srrc_tx_filter: shift without step");

endmodule

/* logic/stream_fifo.sv */
module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  payload_t   wr_data,
    output logic       rd_valid,
    input  logic       rd_ready,
    output payload_t   rd_data,
    output logic [2:0] free
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A full FIFO still takes a write when the head leaves on the same edge
    assign wr_ready = (count != CNT_W'(DEPTH)) || rd_ready;
    assign rd_valid = (count != '0);
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;
    assign rd_data  = mem[rd_ptr];
    assign free     = 3'(DEPTH - int'(count));

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write side wraps onto the head exactly when the buffer is full
    a_full_ptr_match: assert property (@(posedge clk) disable iff (reset)
        (count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr))
        else $error("stream_fifo: write side overran the read side");

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH))
        else $error("stream_fifo: occupancy above depth");

endmodule

/* logic/tx_ctrl_fsm.sv */
module tx_ctrl_fsm (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sym_valid,
    output logic                         sym_ready,
    input  pam_pkg::dibit_in_t           sym_data,
    input  logic [2:0]                   out_free,
    input  logic [srrc_pkg::PHASE_W-1:0] phase,
    input  logic                         sym_strobe,
    output logic                         timer_run,
    output logic                         step,
    output logic                         shift,
    output pam_pkg::sym_code_t           new_sym,
    output logic                         last_mark
);
    import pam_pkg::*;
    import srrc_pkg::*;

    localparam int FLUSH_W = $clog2(SPAN_SYMS + 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH
    } state_t;

    state_t             state;
    state_t             state_nxt;
    logic [FLUSH_W-1:0] flush_cnt;
    logic               active;
    logic               have_sym;

    assign active = (state == RUN) || (state == FLUSH);

    // Flush zeros are always at hand while real symbols come from the FIFO
    assign have_sym = (state == FLUSH) || sym_valid;

    // Two free slots since one sample may still sit in the filter register
    assign timer_run = active && ((phase != '0) || have_sym) && (out_free >= 3'd2);
    assign step      = timer_run;
    assign shift     = sym_strobe && active;
    assign sym_ready = sym_strobe && (state == RUN);
    assign new_sym   = (state == RUN) ? gray_map(sym_data.dibit) : SYM_ZERO;

    // Final phase of the last flush symbol
    assign last_mark = step && (state == FLUSH) && (flush_cnt == FLUSH_W'(SPAN_SYMS))
                       && (phase == PHASE_W'(OSR - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (sym_valid) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (sym_ready && sym_valid && sym_data.last) begin
                    state_nxt = FLUSH;
                end
            end
            FLUSH: begin
                if (last_mark) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state != FLUSH) begin
                flush_cnt <= '0;
            end else if (shift) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    // A boundary in RUN always has a real symbol to pop
    a_run_shift_pops: assert property (@(posedge clk) disable iff (reset)
        (shift && (state == RUN)) |-> sym_valid)
        else $error("tx_ctrl_fsm: symbol boundary in RUN with no symbol to pop");

    // Burst ends on a symbol boundary with the timer back at phase 0
    a_burst_end: assert property (@(posedge clk) disable iff (reset)
        last_mark |=> (state == IDLE) && (phase == '0))
        else $error("tx_ctrl_fsm: burst did not end on a symbol boundary");

endmodule

/* sim/tb_golden.svh */
// Level of a dibit after Gray mapping
function automatic int dibit_level(input logic [1:0] dibit);
    sym_code_t code;
    int        level;
    code = gray_map(dibit);
    case (code)
        SYM_N2:  level = -3;
        SYM_N1:  level = -1;
        SYM_P1:  level = 1;
        SYM_P2:  level = 3;
        default: level = 0;
    endcase
    return level;
endfunction

// Direct convolution of one burst plus its flush zeros from a zero history
// Sample m*OSR+p sums level[m-k] times tap k*OSR+p
task automatic queue_expected(input int first, input int len);
    int          lvl [$];
    int          acc;
    sample_out_t smp;
    for (int i = 0; i < len; i++) begin
        lvl.push_back(dibit_level(beat_q[first + i].dibit));
    end
    for (int i = 0; i < SPAN_SYMS; i++) begin
        lvl.push_back(0);
    end
    for (int m = 0; m < lvl.size(); m++) begin
        for (int p = 0; p < OSR; p++) begin
            acc = 0;
            for (int k = 0; k < SPAN_SYMS; k++) begin
                if (m - k >= 0) begin
                    acc += lvl[m - k] * int'(SRRC_COEF[k * OSR + p]);
                end
            end
            smp.value = SAMPLE_W'(acc);
            smp.last  = (m == lvl.size() - 1) && (p == OSR - 1);
            exp_q.push_back(smp);
        end
    end
endtask

/* sim/tb_pam_tx.sv */
module tb_pam_tx;
    timeunit 1ns;
    timeprecision 1ps;
    import pam_pkg::*;
    import srrc_pkg::*;

    localparam int NUM_BURSTS    = 6;
    localparam int WAIT_TIMEOUT  = 1000;
    localparam int DRAIN_TIMEOUT = 20000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    dibit_in_t   in_data;
    logic        out_valid;
    logic        out_ready;
    sample_out_t out_data;

    dibit_in_t   beat_q [$];
    sample_out_t exp_q [$];
    sample_out_t exp_head;
    int          exp_total = 0;
    int          rd_idx = 0;
    logic        sent_any = 1'b0;
    logic        rand_mode;
    logic [31:0] rnd;
    logic [31:0] rdy_rnd;
    int          burst_len [NUM_BURSTS];
    logic        burst_rand [NUM_BURSTS];

    `include "tb_golden.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic report_and_stop(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Holds one beat on the input until it is taken
    task automatic send_beat(input dibit_in_t beat);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = beat;
        while (!in_ready && waited < WAIT_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            report_and_stop("timeout: in_ready stayed low while a symbol was offered");
        end else begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    pam_tx_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Sink side with random stalls in the bursts that ask for them
    initial begin
        out_ready = 1'b1;
        rdy_rnd   = 32'h732;
        forever begin
            @(posedge clk);
            #1;
            rdy_rnd   = xorshift(rdy_rnd);
            out_ready = rand_mode ? rdy_rnd[4] : 1'b1;
        end
    end

    // Scoreboard pointer into the expected queue
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            rd_idx <= rd_idx + 1;
            if (rd_idx + 1 < exp_total) begin
                exp_head <= exp_q[rd_idx + 1];
            end
        end
        if (!reset && in_valid && in_ready) begin
            sent_any <= 1'b1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !sent_any |-> !out_valid && in_ready)
        else report_and_stop($sformatf(
            "mismatch at %0d ns: out_valid high or in_ready low before the first symbol",
            $time));

    a_sample_value: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> (rd_idx < exp_total) && (out_data == exp_head))
        else report_and_stop($sformatf(
            "mismatch at %0d ns: sample %0d is %0d last %0b, expected %0d last %0b",
            $time, $sampled(rd_idx), $sampled(out_data.value), $sampled(out_data.last),
            $sampled(exp_head.value), $sampled(exp_head.last)));

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_data))
        else report_and_stop($sformatf(
            "mismatch at %0d ns: out_data changed while stalled", $time));

    initial begin
        int first;
        int waited;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        rand_mode = 1'b0;
        rnd       = 32'h732;
        // All bursts and their expected samples are known up front
        for (int b = 0; b < NUM_BURSTS; b++) begin
            rnd           = xorshift(rnd);
            burst_len[b]  = 1 + int'(rnd[3:0]);
            burst_rand[b] = (b == 2) || (b == 3);
            first         = beat_q.size();
            for (int i = 0; i < burst_len[b]; i++) begin
                rnd = xorshift(rnd);
                beat_q.push_back('{dibit: rnd[1:0], last: (i == burst_len[b] - 1)});
            end
            queue_expected(first, burst_len[b]);
        end
        exp_total = exp_q.size();
        exp_head  = exp_q[0];
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        first = 0;
        for (int b = 0; b < NUM_BURSTS; b++) begin
            @(posedge clk);
            rand_mode = burst_rand[b];
            #1;
            for (int i = 0; i < burst_len[b]; i++) begin
                rnd = xorshift(rnd);
                // Input gaps come with the stalled bursts
                if (burst_rand[b]) begin
                    repeat (int'(rnd[1:0])) begin
                        @(posedge clk);
                        #1;
                    end
                end
                send_beat(beat_q[first + i]);
            end
            first += burst_len[b];
        end
        @(posedge clk);
        rand_mode = 1'b0;
        #1;
        waited = 0;
        while (rd_idx < exp_total && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rd_idx < exp_total) begin
            report_and_stop("timeout: not every expected sample left the output stream");
        end else begin
            repeat (4 * OSR) @(posedge clk);
            $display("Everything OK");
            $finish;
        end
    end

endmodule
